// File: include/dhcp_settings.svh
/* Protocol constants for the DHCP receive path: BOOTP byte offsets, option codes
   and message types. Included by the RTL files that decode the payload. */

`ifndef DHCP_SETTINGS_SVH
`define DHCP_SETTINGS_SVH

// BOOTP fixed header
`define DHCP_OP_REPLY        8'h02   // BOOTREPLY, server to client
`define DHCP_XID_FIRST       9'd4    // xid occupies bytes 4..7, msb first
`define DHCP_YIADDR_FIRST    9'd16   // offered address, bytes 16..19
`define DHCP_CHADDR_FIRST    9'd28   // client mac, bytes 28..33
`define DHCP_OPT_FIRST       9'd240  // after the magic cookie at 236..239

// ----------------------------------------------------------------------
// option codes
// ----------------------------------------------------------------------
`define DHCP_OPT_PAD         8'd0
`define DHCP_OPT_END         8'd255
`define DHCP_OPT_MSG_TYPE    8'd53
`define DHCP_OPT_LEASE       8'd51   // lease time in seconds, 4 bytes
`define DHCP_OPT_SERVER_ID   8'd54   // server identifier, 4 bytes

// message type values carried in option 53
`define DHCP_MSG_OFFER       8'd2
`define DHCP_MSG_ACK         8'd5

`endif

// File: logic/dhcp_pkg.sv
/* Shared types for the DHCP receive path, imported by the RTL and the testbench. */

`default_nettype none

package dhcp_pkg;

  // ----------------------------------------------------------------------
  // vectors with a protocol meaning
  // ----------------------------------------------------------------------
  typedef logic [7:0]  byte_t;      // one payload byte
  typedef logic [8:0]  byte_idx_t;  // index into the udp payload
  typedef logic [31:0] ip_addr_t;   // ipv4 address, network order
  typedef logic [47:0] mac_addr_t;  // ethernet mac
  typedef logic [31:0] xid_t;       // transaction id
  typedef logic [31:0] lease_t;     // lease duration in seconds

  // header filter states
  typedef enum logic [1:0] {
    HDR_IDLE,     // waiting for byte 0 of a payload
    HDR_FIELDS,   // inside the fixed bootp header
    HDR_OPTIONS,  // forwarding option bytes to the parser
    HDR_DISCARD   // frame rejected, wait for end of payload
  } hdr_state_t;

  // option parser states
  typedef enum logic [2:0] {
    OPT_CODE,      // expecting an option code
    OPT_LEN,       // expecting the option length
    OPT_MSG_TYPE,  // first value byte of option 53
    OPT_VALUE,     // collecting lease or server id bytes
    OPT_SKIP,      // dropping bytes of an option we do not use
    OPT_DONE       // list finished, idle until next start
  } opt_state_t;

endpackage

`default_nettype wire

// File: logic/dhcp_hdr_filter.sv
/* Checks the BOOTP header of each payload against this station, captures the
   offered address and hands the option bytes on with one cycle of latency. */

`timescale 1ns/1ps
`default_nettype none

`include "dhcp_settings.svh"

module dhcp_hdr_filter (
  input  wire                       rx_clock,
  input  wire                       rst_n,
  input  wire  dhcp_pkg::byte_t     rx_data,
  input  wire                       rx_enable,
  input  wire                       dhcp_rx_active,
  input  wire  dhcp_pkg::xid_t      xid,
  input  wire  dhcp_pkg::mac_addr_t local_mac,
  output dhcp_pkg::ip_addr_t        ip_accept,   // last address offered to us
  output logic                      opt_valid,
  output dhcp_pkg::byte_t           opt_byte,
  output logic                      opt_start
);

  import dhcp_pkg::*;

  hdr_state_t state;
  byte_idx_t  byte_no;     // index of the next byte to arrive
  ip_addr_t   yiaddr_sh;   // offered address, assembled msb first
  mac_addr_t  chaddr_sh;   // client hardware address from the reply

  logic  strobe;           // a payload byte is present this cycle
  logic  in_xid;
  logic  in_yiaddr;
  logic  in_chaddr;
  logic  mac_check;        // chaddr fully assembled
  byte_t xid_byte;         // expected xid byte for the current index

  // ----------------------------------------------------------------------
  // byte position decode
  // ----------------------------------------------------------------------
  assign strobe    = dhcp_rx_active && rx_enable;

  assign in_xid    = (byte_no >= `DHCP_XID_FIRST) &&
                     (byte_no <  `DHCP_XID_FIRST + 9'd4);
  assign in_yiaddr = (byte_no >= `DHCP_YIADDR_FIRST) &&
                     (byte_no <  `DHCP_YIADDR_FIRST + 9'd4);
  assign in_chaddr = (byte_no >= `DHCP_CHADDR_FIRST) &&
                     (byte_no <  `DHCP_CHADDR_FIRST + 9'd6);

  // byte_no reaches 34 right after byte 33 was taken, so the compare
  // runs the cycle after the last chaddr byte whether or not 34 has come
  assign mac_check = (state == HDR_FIELDS) &&
                     (byte_no == `DHCP_CHADDR_FIRST + 9'd6);

  // xid goes out msb first, bytes 4..7 map to index bits 00..11
  always_comb begin
    case (byte_no[1:0])
      2'd0:    xid_byte = xid[31:24];
      2'd1:    xid_byte = xid[23:16];
      2'd2:    xid_byte = xid[15:8];
      default: xid_byte = xid[7:0];
    endcase
  end

  // ----------------------------------------------------------------------
  // header FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge rx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= HDR_IDLE;
      byte_no   <= '0;
      ip_accept <= '0;
      opt_valid <= 1'b0;
      opt_start <= 1'b0;
    end else begin
      opt_valid <= 1'b0;  // single cycle strobes
      opt_start <= 1'b0;

      if (!dhcp_rx_active) begin
        // end of payload, rearm for the next frame
        state   <= HDR_IDLE;
        byte_no <= '0;
      end else begin
        case (state)
          HDR_IDLE: begin
            if (rx_enable) begin
              byte_no <= 9'd1;
              if (rx_data == `DHCP_OP_REPLY)
                state <= HDR_FIELDS;
              else
                state <= HDR_DISCARD;  // a request or junk, not for us
            end
          end

          HDR_FIELDS: begin
            if (rx_enable) begin
              byte_no <= byte_no + 9'd1;
              if (in_xid && (rx_data != xid_byte))
                state <= HDR_DISCARD;  // someone else's transaction
              if (byte_no == `DHCP_OPT_FIRST) begin
                opt_valid <= 1'b1;     // first option code
                opt_start <= 1'b1;
                state     <= HDR_OPTIONS;
              end
            end
            // placed after the strobe branch so a mismatch wins
            if (mac_check) begin
              if (chaddr_sh == local_mac)
                ip_accept <= yiaddr_sh;
              else
                state <= HDR_DISCARD;
            end
          end

          HDR_OPTIONS: begin
            if (rx_enable)
              opt_valid <= 1'b1;  // counter no longer needed here
          end

          default: begin
            // HDR_DISCARD holds until dhcp_rx_active drops
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // payload capture
  // ----------------------------------------------------------------------
  always_ff @(posedge rx_clock) begin
    if (strobe && (state == HDR_FIELDS)) begin
      if (in_yiaddr)
        yiaddr_sh <= {yiaddr_sh[23:0], rx_data};
      if (in_chaddr)
        chaddr_sh <= {chaddr_sh[39:0], rx_data};
    end
    if (strobe)
      opt_byte <= rx_data;  // qualified downstream by opt_valid
  end

endmodule

`default_nettype wire

// File: logic/dhcp_opt_parser.sv
/* Walks the DHCP option list of an accepted reply. Flags OFFER and ACK outcomes
   and latches lease and server identifier once the ACK list ends. */

`timescale 1ns/1ps
`default_nettype none

`include "dhcp_settings.svh"

module dhcp_opt_parser (
  input  wire                   rx_clock,
  input  wire                   rst_n,
  input  wire                   opt_valid,
  input  wire  dhcp_pkg::byte_t opt_byte,
  input  wire                   opt_start,     // new list begins with this byte
  output dhcp_pkg::lease_t      lease,
  output dhcp_pkg::ip_addr_t    server_ip,
  output logic                  offer_pulse,
  output logic                  dhcp_success,
  output logic                  dhcp_failed
);

  import dhcp_pkg::*;

  opt_state_t state;
  opt_state_t cur;         // state the current byte is decoded in
  byte_t      code;        // code of the option being read
  byte_t      remain;      // value bytes still to come, this one included
  logic       ack_seen;    // message type 5 seen in this list
  logic       ack_live;
  lease_t     lease_sh;    // shadow copies, published on END
  ip_addr_t   server_sh;

  // a start byte is always a code, whatever the previous list left behind
  assign cur      = opt_start ? OPT_CODE : state;
  assign ack_live = ack_seen && !opt_start;

  // ----------------------------------------------------------------------
  // option FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge rx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state        <= OPT_DONE;
      code         <= '0;
      remain       <= '0;
      ack_seen     <= 1'b0;
      lease        <= '0;
      server_ip    <= '0;
      offer_pulse  <= 1'b0;
      dhcp_success <= 1'b0;
      dhcp_failed  <= 1'b0;
    end else begin
      offer_pulse <= 1'b0;
      if (opt_valid) begin
        if (opt_start)
          ack_seen <= 1'b0;

        case (cur)
          OPT_CODE: begin
            if (opt_byte == `DHCP_OPT_END) begin
              state <= OPT_DONE;
              if (ack_live) begin
                lease        <= lease_sh;
                server_ip    <= server_sh;
                dhcp_success <= 1'b1;
                dhcp_failed  <= 1'b0;
              end
            end else if (opt_byte == `DHCP_OPT_PAD) begin
              state <= OPT_CODE;  // explicit, state may have been DONE
            end else begin
              code  <= opt_byte;
              state <= OPT_LEN;
            end
          end

          OPT_LEN: begin
            remain <= opt_byte;
            if (opt_byte == 8'd0)
              state <= OPT_CODE;    // empty option
            else if (code == `DHCP_OPT_MSG_TYPE)
              state <= OPT_MSG_TYPE;
            else if ((code == `DHCP_OPT_LEASE) || (code == `DHCP_OPT_SERVER_ID))
              state <= OPT_VALUE;
            else
              state <= OPT_SKIP;    // unknown, skip by length
          end

          OPT_MSG_TYPE: begin
            remain <= remain - 8'd1;
            if (opt_byte == `DHCP_MSG_OFFER) begin
              offer_pulse <= 1'b1;  // tx side answers with REQUEST
              state       <= OPT_DONE;
            end else if (opt_byte == `DHCP_MSG_ACK) begin
              ack_seen <= 1'b1;
              if (remain == 8'd1)
                state <= OPT_CODE;
              else
                state <= OPT_SKIP;
            end else begin
              // NAK or anything else ends the exchange
              dhcp_failed  <= 1'b1;
              dhcp_success <= 1'b0;
              state        <= OPT_DONE;
            end
          end

          OPT_VALUE, OPT_SKIP: begin
            remain <= remain - 8'd1;
            if (remain == 8'd1)
              state <= OPT_CODE;
          end

          default: begin
            // OPT_DONE ignores bytes until the next opt_start
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // shadow registers
  // ----------------------------------------------------------------------
  // seeded from the outputs at list start so a missing option keeps
  // the previous value; longer options keep their last four bytes
  always_ff @(posedge rx_clock) begin
    if (opt_valid && opt_start) begin
      lease_sh  <= lease;
      server_sh <= server_ip;
    end else if (opt_valid && (cur == OPT_VALUE)) begin
      if (code == `DHCP_OPT_LEASE)
        lease_sh  <= {lease_sh[23:0], opt_byte};
      else
        server_sh <= {server_sh[23:0], opt_byte};
    end
  end

endmodule

`default_nettype wire

// File: logic/dhcp_rx_top.sv
/* Receive side of the DHCP client. Feed it the UDP payload for port 68; it
   reports the offered address, lease, server and the outcome of the exchange. */

`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_top (
  input  wire                      rx_clock,
  input  wire                      rst_n,
  // payload stream from the udp layer
  input  wire  dhcp_pkg::byte_t    rx_data,
  input  wire                      rx_enable,       // one byte per strobe
  input  wire                      dhcp_rx_active,  // high for the whole payload
  // station identity, held stable by the system
  input  wire  dhcp_pkg::xid_t     xid,
  input  wire  dhcp_pkg::mac_addr_t local_mac,
  // results
  output wire  dhcp_pkg::ip_addr_t ip_accept,
  output wire  dhcp_pkg::lease_t   lease,
  output wire  dhcp_pkg::ip_addr_t server_ip,
  output wire                      offer_pulse,     // request the tx side to send REQUEST
  output wire                      dhcp_success,
  output wire                      dhcp_failed
);

  import dhcp_pkg::*;

  // ----------------------------------------------------------------------
  // filter to parser link
  // ----------------------------------------------------------------------
  logic  opt_valid;  // one strobe per option byte
  byte_t opt_byte;
  logic  opt_start;  // first option byte of an accepted frame

  // header checks and yiaddr capture
  dhcp_hdr_filter u_hdr_filter (
    .rx_clock       (rx_clock),
    .rst_n          (rst_n),
    .rx_data        (rx_data),
    .rx_enable      (rx_enable),
    .dhcp_rx_active (dhcp_rx_active),
    .xid            (xid),
    .local_mac      (local_mac),
    .ip_accept      (ip_accept),
    .opt_valid      (opt_valid),
    .opt_byte       (opt_byte),
    .opt_start      (opt_start)
  );

  // option walk, one byte per clock, never stalls
  dhcp_opt_parser u_opt_parser (
    .rx_clock     (rx_clock),
    .rst_n        (rst_n),
    .opt_valid    (opt_valid),
    .opt_byte     (opt_byte),
    .opt_start    (opt_start),
    .lease        (lease),
    .server_ip    (server_ip),
    .offer_pulse  (offer_pulse),
    .dhcp_success (dhcp_success),
    .dhcp_failed  (dhcp_failed)
  );

endmodule

`default_nettype wire

// File: sim/dhcp_rx_chk.sv
/* Concurrent rules on the DHCP receive outputs. Bound into the top level so any
   simulation of dhcp_rx_top picks them up. */

`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_chk (
  input wire rx_clock,
  input wire rst_n,
  input wire rx_enable,
  input wire offer_pulse,
  input wire dhcp_success,
  input wire dhcp_failed
);

  int unsigned fail_count = 0;  // assertion failures so far
  logic        enable_seen;     // first payload strobe has happened

  always_ff @(posedge rx_clock or negedge rst_n) begin
    if (!rst_n)
      enable_seen <= 1'b0;
    else if (rx_enable)
      enable_seen <= 1'b1;
  end

  // ----------------------------------------------------------------------
  // output rules
  // ----------------------------------------------------------------------
  // request to the tx side is one cycle wide
  offer_single: assert property (@(posedge rx_clock) disable iff (!rst_n)
    offer_pulse |=> !offer_pulse)
    else begin
      $error("offer_pulse stayed high for two cycles");
      fail_count++;
    end

  // outcome levels are exclusive
  outcome_exclusive: assert property (@(posedge rx_clock) disable iff (!rst_n)
    !(dhcp_success && dhcp_failed))
    else begin
      $error("dhcp_success and dhcp_failed are high together");
      fail_count++;
    end

  // nothing decided before any payload byte arrived
  quiet_after_reset: assert property (@(posedge rx_clock) disable iff (!rst_n)
    !enable_seen |-> (!dhcp_success && !dhcp_failed))
    else begin
      $error("outcome level set before the first payload byte");
      fail_count++;
    end

endmodule

bind dhcp_rx_top dhcp_rx_chk u_chk (
  .rx_clock     (rx_clock),
  .rst_n        (rst_n),
  .rx_enable    (rx_enable),
  .offer_pulse  (offer_pulse),
  .dhcp_success (dhcp_success),
  .dhcp_failed  (dhcp_failed)
);

`default_nettype wire

// File: sim/dhcp_rx_tb.sv
/* Testbench for the DHCP receive path. Builds reply payloads, streams them with
   random gaps and checks address, lease, server and outcome against the sent fields. */

`timescale 1ns/1ps
`default_nettype none

`include "dhcp_settings.svh"

module dhcp_rx_tb;

  import dhcp_pkg::*;

  localparam int PKT_LEN = 300;   // payload bytes per frame
  localparam int WAIT_MAX = 2000; // cycles before a wait gives up

  localparam xid_t      MY_XID = 32'h3c5a_9e17;
  localparam mac_addr_t MY_MAC = 48'h02_1a_2b_3c_4d_5e;

  logic      rx_clock;
  logic      rst_n;
  byte_t     rx_data;
  logic      rx_enable;
  logic      dhcp_rx_active;
  xid_t      xid;
  mac_addr_t local_mac;
  ip_addr_t  ip_accept;
  lease_t    lease;
  ip_addr_t  server_ip;
  wire       offer_pulse;
  wire       dhcp_success;
  wire       dhcp_failed;

  integer seed = 32'h8d6b_1a00;
  byte_t  pkt [0:PKT_LEN-1];  // payload under construction
  int     opt_ptr;            // next free option byte
  int     offer_count = 0;    // offer pulses seen since reset

  dhcp_rx_top DUT (
    .rx_clock(rx_clock), .rst_n(rst_n), .rx_data(rx_data), .rx_enable(rx_enable),
    .dhcp_rx_active(dhcp_rx_active), .xid(xid), .local_mac(local_mac),
    .ip_accept(ip_accept), .lease(lease), .server_ip(server_ip),
    .offer_pulse(offer_pulse), .dhcp_success(dhcp_success), .dhcp_failed(dhcp_failed)
  );

  initial begin
    rx_clock = 1'b0;
    forever #50 rx_clock = ~rx_clock;  // 100 ns period
  end

  always @(posedge rx_clock) begin
    if (offer_pulse)
      offer_count <= offer_count + 1;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic expect_hex(input string name, input logic [47:0] expected,
                            input logic [47:0] actual);
    assert (actual === expected)
    else begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // fixed bootp header with an index pattern in the unchecked fields
  task automatic build_header(input byte_t op, input xid_t x, input mac_addr_t mac,
                              input ip_addr_t yi);
    int i;
    for (i = 0; i < PKT_LEN; i++)
      pkt[i] = byte_t'(i ^ (i >> 8) ^ 8'h5a);
    pkt[0] = op;
    for (i = 0; i < 4; i++) begin
      pkt[4 + i]  = x[31 - 8*i -: 8];   // msb first
      pkt[16 + i] = yi[31 - 8*i -: 8];
    end
    for (i = 0; i < 6; i++)
      pkt[28 + i] = mac[47 - 8*i -: 8];
    pkt[236] = 8'h63;  // magic cookie
    pkt[237] = 8'h82;
    pkt[238] = 8'h53;
    pkt[239] = 8'h63;
    opt_ptr = 240;
  endtask

  task automatic add_byte(input byte_t b);
    pkt[opt_ptr] = b;
    opt_ptr++;
  endtask

  task automatic add_word(input logic [31:0] w);
    int i;
    for (i = 0; i < 4; i++)
      add_byte(w[31 - 8*i -: 8]);
  endtask

  // option 53 with a single value byte
  task automatic add_msg_type(input byte_t msg);
    add_byte(`DHCP_OPT_MSG_TYPE);
    add_byte(8'd1);
    add_byte(msg);
  endtask

  // four byte option such as lease or server id
  task automatic add_long_option(input byte_t code, input logic [31:0] value);
    add_byte(code);
    add_byte(8'd4);
    add_word(value);
  endtask

  // one strobe per byte with 0..3 idle cycles in front of each
  task automatic send_frame();
    int i;
    int gap;
    @(posedge rx_clock);
    dhcp_rx_active <= 1'b1;
    for (i = 0; i < PKT_LEN; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge rx_clock);
        rx_enable <= 1'b0;
      end
      @(posedge rx_clock);
      rx_data   <= pkt[i];
      rx_enable <= 1'b1;
    end
    @(posedge rx_clock);
    rx_enable <= 1'b0;
    repeat (4) @(posedge rx_clock);  // parser output lags by two edges
    dhcp_rx_active <= 1'b0;
    repeat (2) @(posedge rx_clock);
  endtask

  task automatic wait_offer_count(input int n);
    int cycles;
    cycles = 0;
    while ((offer_count != n) && (cycles < WAIT_MAX)) begin
      @(posedge rx_clock);
      cycles++;
    end
    if (offer_count != n) begin
      $display("timeout while waiting for the offer pulse");
      $display("TESTS FAILED");
      $fatal(1, "no offer pulse");
    end
  endtask

  task automatic wait_outcome(input logic succ, input logic fail);
    int cycles;
    cycles = 0;
    while (((dhcp_success !== succ) || (dhcp_failed !== fail)) && (cycles < WAIT_MAX)) begin
      @(posedge rx_clock);
      cycles++;
    end
    if ((dhcp_success !== succ) || (dhcp_failed !== fail)) begin
      $display("timeout while waiting for the success and failed levels");
      $display("TESTS FAILED");
      $fatal(1, "outcome not reached");
    end
  endtask

  task automatic expect_state(input ip_addr_t ip, input lease_t ls, input ip_addr_t srv,
                              input logic succ, input logic fail, input int offers);
    expect_hex("ip_accept", ip, ip_accept);
    expect_hex("lease", ls, lease);
    expect_hex("server_ip", srv, server_ip);
    expect_hex("dhcp_success", succ, dhcp_success);
    expect_hex("dhcp_failed", fail, dhcp_failed);
    expect_hex("offer_count", offers, offer_count);
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    rx_data        = '0;
    rx_enable      = 1'b0;
    dhcp_rx_active = 1'b0;
    xid            = MY_XID;
    local_mac      = MY_MAC;
    repeat (16) @(posedge rx_clock);
    rst_n <= 1'b1;
    @(posedge rx_clock);
    expect_state(32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 0);

    // offer for us gives one request pulse and the new address
    build_header(`DHCP_OP_REPLY, MY_XID, MY_MAC, 32'hc0a8_0164);
    add_msg_type(`DHCP_MSG_OFFER);
    add_byte(`DHCP_OPT_END);
    send_frame();
    wait_offer_count(1);
    expect_state(32'hc0a8_0164, 32'h0, 32'h0, 1'b0, 1'b0, 1);

    // padded ack carrying an unknown option and server id before lease
    build_header(`DHCP_OP_REPLY, MY_XID, MY_MAC, 32'hc0a8_0165);
    add_byte(`DHCP_OPT_PAD);
    add_msg_type(`DHCP_MSG_ACK);
    add_byte(`DHCP_OPT_PAD);
    add_byte(`DHCP_OPT_PAD);
    add_byte(8'd12);  // host name option that the parser skips
    add_byte(8'd3);
    add_byte(8'h68);
    add_byte(8'h73);
    add_byte(8'h74);
    add_long_option(`DHCP_OPT_SERVER_ID, 32'hc0a8_0101);
    add_long_option(`DHCP_OPT_LEASE, 32'h0000_0e10);
    add_byte(`DHCP_OPT_END);
    send_frame();
    wait_outcome(1'b1, 1'b0);
    expect_state(32'hc0a8_0165, 32'h0000_0e10, 32'hc0a8_0101, 1'b1, 1'b0, 1);

    // ack with one xid byte off is ignored
    build_header(`DHCP_OP_REPLY, MY_XID ^ 32'h00ff_0000, MY_MAC, 32'hc0a8_0199);
    add_msg_type(`DHCP_MSG_ACK);
    add_long_option(`DHCP_OPT_LEASE, 32'h0000_1234);
    add_byte(`DHCP_OPT_END);
    send_frame();
    expect_state(32'hc0a8_0165, 32'h0000_0e10, 32'hc0a8_0101, 1'b1, 1'b0, 1);

    // offer addressed to another mac
    build_header(`DHCP_OP_REPLY, MY_XID, MY_MAC ^ 48'h1, 32'hc0a8_01aa);
    add_msg_type(`DHCP_MSG_OFFER);
    add_byte(`DHCP_OPT_END);
    send_frame();
    expect_state(32'hc0a8_0165, 32'h0000_0e10, 32'hc0a8_0101, 1'b1, 1'b0, 1);

    // bootrequest op is not a reply
    build_header(8'h01, MY_XID, MY_MAC, 32'hc0a8_01bb);
    add_msg_type(`DHCP_MSG_ACK);
    add_long_option(`DHCP_OPT_LEASE, 32'h0000_7777);
    add_byte(`DHCP_OPT_END);
    send_frame();
    expect_state(32'hc0a8_0165, 32'h0000_0e10, 32'hc0a8_0101, 1'b1, 1'b0, 1);

    // nak leaves lease and server as they were
    build_header(`DHCP_OP_REPLY, MY_XID, MY_MAC, 32'hc0a8_0170);
    add_msg_type(8'd6);
    add_byte(`DHCP_OPT_END);
    send_frame();
    wait_outcome(1'b0, 1'b1);
    expect_state(32'hc0a8_0170, 32'h0000_0e10, 32'hc0a8_0101, 1'b0, 1'b1, 1);

    // good ack again with lease before server id
    build_header(`DHCP_OP_REPLY, MY_XID, MY_MAC, 32'hc0a8_0171);
    add_msg_type(`DHCP_MSG_ACK);
    add_long_option(`DHCP_OPT_LEASE, 32'h0001_5180);
    add_long_option(`DHCP_OPT_SERVER_ID, 32'hc0a8_0102);
    add_byte(`DHCP_OPT_END);
    send_frame();
    wait_outcome(1'b1, 1'b0);
    expect_state(32'hc0a8_0171, 32'h0001_5180, 32'hc0a8_0102, 1'b1, 1'b0, 1);

    if (DUT.u_chk.fail_count != 0) begin
      $display("TESTS FAILED");
      $fatal(1, "bound assertions failed %0d times", DUT.u_chk.fail_count);
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/dhcp_pkg.sv
logic/dhcp_hdr_filter.sv
logic/dhcp_opt_parser.sv
logic/dhcp_rx_top.sv
sim/dhcp_rx_chk.sv
sim/dhcp_rx_tb.sv
